//--- src/gate_pkg.sv
package gate_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int SAMPLE_W     = 14;
    localparam int BYTE_W       = 8;

    // kept small so that a test can fill it.
    localparam int FIFO_DEPTH   = 4;
    localparam int PTR_W        = $clog2(FIFO_DEPTH);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // uart timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int CLKS_PER_BIT = 8;
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);
    localparam int IDX_W        = $clog2(BYTE_W);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bundled signals
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one adc sample plus the ready flag of the converter.
    typedef struct packed {
        logic [SAMPLE_W-1:0] sample;
        logic                init;
    } adc_in_t;

    // head of the peak queue as seen by the transmitter.
    typedef struct packed {
        logic [BYTE_W-1:0] data;
        logic              valid;
    } peak_t;

endpackage

//--- src/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo (
    input  logic                        clock,
    input  logic                        i_rst_n,
    input  logic                        i_wr,
    input  logic [gate_pkg::BYTE_W-1:0] i_wdata,
    input  logic                        i_rd,
    output logic [gate_pkg::BYTE_W-1:0] o_rdata,
    output logic                        o_empty,
    output logic                        o_full
);
    import gate_pkg::*;

    logic [BYTE_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              do_wr;
    logic              do_rd;

    // a write into a full buffer and a read from an empty one are dropped.
    assign do_wr = i_wr & ~o_full;
    assign do_rd = i_rd & ~o_empty;

    assign o_empty = (count == '0);
    assign o_full  = (count == (PTR_W + 1)'(FIFO_DEPTH));

    // the head entry is always on the output so that the first word falls through.
    assign o_rdata = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    // the depth is a power of two, so the pointers wrap on their own.
    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            count <= '0;
        end else begin
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- src/gate_buffer.sv
`timescale 1ns/1ps

module gate_buffer (
    input  logic              clock,
    input  logic              i_rst_n,
    input  gate_pkg::adc_in_t i_adc,
    input  logic              i_gate,
    input  logic              i_next,
    output gate_pkg::peak_t   o_peak,
    output logic              o_overflow
);
    import gate_pkg::*;

    logic                gate_s1;
    logic                gate_s2;
    logic                gate_d;
    logic                win_rise;
    logic                win_fall;
    logic                win_armed;
    logic [SAMPLE_W-1:0] peak_q;
    logic                wr_req;
    logic [BYTE_W-1:0]   wr_byte;
    logic [BYTE_W-1:0]   fifo_rdata;
    logic                fifo_empty;
    logic                fifo_full;
    logic                pop;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // gate synchroniser and edges
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            gate_s1 <= 1'b0;
            gate_s2 <= 1'b0;
            gate_d  <= 1'b0;
        end else begin
            gate_s1 <= i_gate;
            gate_s2 <= gate_s1;
            gate_d  <= gate_s2;
        end
    end

    assign win_rise = gate_s2 & ~gate_d;
    assign win_fall = ~gate_s2 & gate_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // window peak tracking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a window only counts when the adc was ready as it opened.
    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            win_armed <= 1'b0;
        end else if (win_rise) begin
            win_armed <= i_adc.init;
        end
    end

    always_ff @(posedge clock) begin
        if (gate_s2 && i_adc.init) begin
            if (win_rise || (i_adc.sample > peak_q)) begin
                peak_q <= i_adc.sample;
            end
        end
    end

    // the byte is the top bits of the peak, written one cycle after the close.
    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            wr_req <= 1'b0;
        end else begin
            wr_req <= win_fall & win_armed;
        end
    end

    always_ff @(posedge clock) begin
        if (win_fall) begin
            wr_byte <= peak_q[SAMPLE_W-1 -: BYTE_W];
        end
    end

    // sticky until reset.
    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            o_overflow <= 1'b0;
        end else if (wr_req && fifo_full) begin
            o_overflow <= 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // peak queue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign pop = o_peak.valid & i_next;

    sample_fifo u_sample_fifo (
        .clock   (clock),
        .i_rst_n (i_rst_n),
        .i_wr    (wr_req),
        .i_wdata (wr_byte),
        .i_rd    (pop),
        .o_rdata (fifo_rdata),
        .o_empty (fifo_empty),
        .o_full  (fifo_full)
    );

    assign o_peak.data  = fifo_rdata;
    assign o_peak.valid = ~fifo_empty;

endmodule

//--- src/tx_unit.sv
`timescale 1ns/1ps

module tx_unit (
    input  logic                        clock,
    input  logic                        i_rst_n,
    input  logic                        i_send,
    input  logic [gate_pkg::BYTE_W-1:0] i_txdata,
    output logic                        o_txready,
    output logic                        o_tx
);
    import gate_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } tx_state_t;

    tx_state_t          state;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [IDX_W-1:0]   bit_idx;
    logic [BYTE_W-1:0]  shift_reg;
    logic               bit_done;
    logic               take;

    assign o_txready = (state == ST_IDLE);
    assign take      = i_send & o_txready;
    assign bit_done  = (bit_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            if (state == ST_IDLE || bit_done) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    if (bit_done) begin
                        state   <= ST_DATA;
                        bit_idx <= '0;
                    end
                end
                ST_DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_W'(BYTE_W - 1)) begin
                            state <= ST_STOP;
                        end
                    end
                end
                ST_STOP: begin
                    if (bit_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // lsb goes out first, so the register moves right after each data bit.
    always_ff @(posedge clock) begin
        if (take) begin
            shift_reg <= i_txdata;
        end else if (state == ST_DATA && bit_done) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    always_comb begin
        case (state)
            ST_START: o_tx = 1'b0;
            ST_DATA:  o_tx = shift_reg[0];
            default:  o_tx = 1'b1;
        endcase
    end

endmodule

//--- src/gate_link_top.sv
`timescale 1ns/1ps

module gate_link_top (
    input  logic              clock,
    input  logic              i_rst_n,
    input  gate_pkg::adc_in_t i_adc,
    input  logic              i_gate,
    output logic              o_tx,
    output logic              o_overflow
);
    import gate_pkg::*;

    // head of the peak queue and the transmitter's idle flag.
    peak_t peak;
    logic  txready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // capture side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    gate_buffer u_gate_buffer (
        .clock      (clock),
        .i_rst_n    (i_rst_n),
        .i_adc      (i_adc),
        .i_gate     (i_gate),
        .i_next     (txready),
        .o_peak     (peak),
        .o_overflow (o_overflow)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // serial side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    tx_unit u_tx_unit (
        .clock     (clock),
        .i_rst_n   (i_rst_n),
        .i_send    (peak.valid),
        .i_txdata  (peak.data),
        .o_txready (txready),
        .o_tx      (o_tx)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic o_clock,
    output logic o_rst_n
);

    // 4 ns period.
    initial begin
        o_clock = 1'b0;
        forever begin
            #2 o_clock = ~o_clock;
        end
    end

    // reset is held low for the first four rising edges.
    initial begin
        o_rst_n = 1'b0;
        repeat (4) @(posedge o_clock);
        o_rst_n <= 1'b1;
    end

endmodule

//--- test/gate_link_checker.sv
`timescale 1ns/1ps

module gate_link_checker (
    input logic clock,
    input logic i_rst_n,
    input logic i_tx,
    input logic i_overflow
);
    import gate_pkg::*;

    logic [BYTE_W-1:0] exp_q [$];
    int                errors = 0;
    int                frames_seen = 0;
    logic              ovf_allowed = 1'b0;
    logic              ovf_seen = 1'b0;
    logic              early_reported = 1'b0;

    task automatic push_expected(input logic [BYTE_W-1:0] b);
        exp_q.push_back(b);
    endtask

    task automatic allow_overflow();
        ovf_allowed = 1'b1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // serial frame decoder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the first low sample is early in the start bit, so wait to its middle.
    always begin
        logic [BYTE_W-1:0] got;
        logic [BYTE_W-1:0] want;
        @(posedge clock);
        if (i_rst_n && i_tx == 1'b0) begin
            got = '0;
            repeat (CLKS_PER_BIT / 2 - 1) @(posedge clock);
            if (i_tx != 1'b0) begin
                errors++;
                $display("** Error o_tx start bit got %h expected %h at %0t",
                         i_tx, 1'b0, $time);
            end
            for (int i = 0; i < BYTE_W; i++) begin
                repeat (CLKS_PER_BIT) @(posedge clock);
                got[i] = i_tx;
            end
            repeat (CLKS_PER_BIT) @(posedge clock);
            if (i_tx != 1'b1) begin
                errors++;
                $display("** Error o_tx stop bit got %h expected %h in frame %0d",
                         i_tx, 1'b1, frames_seen);
            end
            frames_seen++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected extra frame on o_tx carrying %h", got);
            end else begin
                want = exp_q.pop_front();
                if (got !== want) begin
                    errors++;
                    $display("** Error o_tx byte got %h expected %h", got, want);
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // overflow flag
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clock) begin
        if (i_rst_n) begin
            if (i_overflow && !ovf_allowed && !early_reported) begin
                errors++;
                early_reported = 1'b1;
                $display("overflow rose before any window was meant to be dropped");
            end
            if (ovf_seen && !i_overflow) begin
                errors++;
                $display("overflow flag fell again without a reset at %0t", $time);
            end
            ovf_seen = ovf_seen | i_overflow;
        end
    end

    task automatic final_check(input logic exp_ovf);
        if (i_overflow !== exp_ovf) begin
            errors++;
            $display("** Error o_overflow got %h expected %h", i_overflow, exp_ovf);
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected frames never arrived on o_tx", exp_q.size());
        end
    endtask

endmodule

//--- test/gate_link_tb.sv
`timescale 1ns/1ps

module gate_link_tb;
    import gate_pkg::*;

    logic    clock;
    logic    rst_n;
    adc_in_t adc;
    logic    gate;
    logic    tx;
    logic    overflow;

    int cycles = 0;
    int limit = 0;
    int tb_errors = 0;

    int c_init [$];
    int c_start [$];
    int c_step [$];
    int c_len [$];
    int c_gap [$];
    int c_drop [$];

    tb_clock u_clock (
        .o_clock (clock),
        .o_rst_n (rst_n)
    );

    gate_link_top uut (
        .clock      (clock),
        .i_rst_n    (rst_n),
        .i_adc      (adc),
        .i_gate     (gate),
        .o_tx       (tx),
        .o_overflow (overflow)
    );

    gate_link_checker u_checker (
        .clock      (clock),
        .i_rst_n    (rst_n),
        .i_tx       (tx),
        .i_overflow (overflow)
    );

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles waiting for frames", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // samples lag the gate by the two synchroniser flops, so the ramp lines up
    // with the cycles that the window logic sees.
    task automatic drive_window(input int init_v, input int start, input int step,
                                input int len, input int gap);
        int val;
        for (int c = 0; c < len + gap; c++) begin
            @(posedge clock);
            gate <= (c < len);
            adc.init <= (init_v != 0);
            if (c >= 2 && c < len + 2) begin
                val = start + (c - 2) * step;
                adc.sample <= SAMPLE_W'(val);
            end else begin
                adc.sample <= SAMPLE_W'($urandom);
            end
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    v_init;
        int    v_start;
        int    v_step;
        int    v_len;
        int    v_gap;
        int    v_exp;
        int    v_drop;
        int    n_exp;
        logic  exp_ovf;
        string line;
        void'($urandom(32'h9c1a));
        adc = '0;
        gate = 1'b0;
        n_exp = 0;
        exp_ovf = 1'b0;
        fd = $fopen("test/gate_cases.txt", "r");
        if (fd == 0) begin
            tb_errors++;
            $display("could not open test/gate_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %h %d",
                                v_init, v_start, v_step, v_len, v_gap, v_exp, v_drop);
                    if (n == 7) begin
                        c_init.push_back(v_init);
                        c_start.push_back(v_start);
                        c_step.push_back(v_step);
                        c_len.push_back(v_len);
                        c_gap.push_back(v_gap);
                        c_drop.push_back(v_drop);
                        if (v_drop != 0) begin
                            exp_ovf = 1'b1;
                        end else if (v_init != 0) begin
                            u_checker.push_expected(BYTE_W'(v_exp));
                            n_exp++;
                        end
                    end else begin
                        tb_errors++;
                        $display("malformed line in cases file: %s", line);
                    end
                end
            end
            $fclose(fd);
        end

        limit = 200 + 4 + n_exp * 10 * CLKS_PER_BIT;
        foreach (c_len[i]) begin
            limit += c_len[i] + c_gap[i];
        end

        while (rst_n !== 1'b1) @(posedge clock);
        foreach (c_len[i]) begin
            if (c_drop[i] != 0) begin
                u_checker.allow_overflow();
            end
            drive_window(c_init[i], c_start[i], c_step[i], c_len[i], c_gap[i]);
        end
        while (u_checker.frames_seen < n_exp) @(posedge clock);
        // room for a stray frame to show up.
        repeat (12 * CLKS_PER_BIT) @(posedge clock);
        u_checker.final_check(exp_ovf);

        $display("closing: %0d errors (%0d checker, %0d testbench), %0d of %0d frames",
                 u_checker.errors + tb_errors, u_checker.errors, tb_errors,
                 u_checker.frames_seen, n_exp);
        if (u_checker.errors + tb_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- test/gate_cases.txt
# init start step len gap byte(hex) drop ; byte = peak/64, drop=1 means lost to overflow
# init=0 windows give no frame
0 5000 10 8 30 00 0
1 1000 100 10 150 1d 0
1 16000 -200 10 150 fa 0
1 8191 0 6 150 7f 0
1 64 3 5 150 01 0
1 4096 1 4 4 40 0
1 8192 2 4 4 80 0
1 12288 -1 4 4 c0 0
1 2048 5 4 4 20 0
1 10000 7 4 450 9c 0
1 640 0 4 4 0a 0
1 1280 0 4 4 14 0
1 1920 0 4 4 1e 0
1 2560 0 4 4 28 0
1 3200 0 4 4 32 0
1 3840 0 4 4 ff 1
1 4480 0 4 450 ff 1
1 6400 10 8 150 65 0

//--- sim.f
src/gate_pkg.sv
src/sample_fifo.sv
src/gate_buffer.sv
src/tx_unit.sv
src/gate_link_top.sv
test/tb_clock.sv
test/gate_link_checker.sv
test/gate_link_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the gate link testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary -f sim.f --top-module gate_link_tb -o gate_link_sim

./obj_dir/gate_link_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
